// File: tests/bpred_vectors.txt
# Columns: res_valid res_pc res_target res_taken res_mispredict fetch_ready
#          exp_fetch_pc exp_pred_taken exp_pred_target (hex, one line per cycle)
# Expected target is compared only where the expected taken flag is 1
#
# Sequential fetch from boot PC, empty BTB
0 00000000 00000000 0 0 1 00000000 0 00000000
0 00000000 00000000 0 0 1 00000004 0 00000000
0 00000000 00000000 0 0 1 00000008 0 00000000
0 00000000 00000000 0 0 1 0000000c 0 00000000
# Back-pressure, PC holds
0 00000000 00000000 0 0 0 00000010 0 00000000
0 00000000 00000000 0 0 0 00000010 0 00000000
0 00000000 00000000 0 0 0 00000010 0 00000000
0 00000000 00000000 0 0 0 00000010 0 00000000
0 00000000 00000000 0 0 1 00000010 0 00000000
# Taken mispredict at 0x40 redirects to 0x100
1 00000040 00000100 1 1 1 00000014 0 00000000
# Train 0x40 taken until history saturates
1 00000040 00000100 1 0 1 00000100 0 00000000
1 00000040 00000100 1 0 1 00000104 0 00000000
1 00000040 00000100 1 0 1 00000108 0 00000000
1 00000040 00000100 1 0 1 0000010c 0 00000000
# Taken mispredict at 0x110 jumps back to 0x40
1 00000110 00000040 1 1 1 00000110 0 00000000
# 0x40 now predicted taken to 0x100
0 00000000 00000000 0 0 1 00000040 1 00000100
# 0x100 shares BTB index 0 with another tag, miss
0 00000000 00000000 0 0 1 00000100 0 00000000
0 00000000 00000000 0 0 1 00000104 0 00000000
# Not-taken mispredict at 0x40 evicts it, fetch goes to 0x44
1 00000040 00000100 0 1 1 00000108 0 00000000
# Taken mispredict at 0x48 sends fetch back to 0x40
1 00000048 00000040 1 1 1 00000044 0 00000000
0 00000000 00000000 0 0 1 00000040 0 00000000
0 00000000 00000000 0 0 1 00000044 0 00000000
0 00000000 00000000 0 0 1 00000048 0 00000000
0 00000000 00000000 0 0 1 0000004c 0 00000000
# 0x50 hits index 4 under a different tag
0 00000000 00000000 0 0 1 00000050 0 00000000
0 00000000 00000000 0 0 1 00000054 0 00000000
0 00000000 00000000 0 0 1 00000058 0 00000000
0 00000000 00000000 0 0 1 0000005c 0 00000000
# Redirect while fetch is stalled
1 00000200 00000300 1 1 0 00000060 0 00000000
0 00000000 00000000 0 0 1 00000300 0 00000000
0 00000000 00000000 0 0 1 00000304 0 00000000

// File: bpred.f
verilog/bpred_pkg.sv
verilog/gshare.sv
verilog/btb.sv
verilog/bpu.sv
verilog/bpred_pc_gen.sv
verilog/bpred_top.sv
tests/bpred_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f bpred.f \
  --top-module bpred_tb \
  -o bpred_sim

sim_out=$(./obj_dir/bpred_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi

// File: tests/bpred_tb.sv
module bpred_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import bpred_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 10;

  // DUT ports
  logic            clk_i;
  logic            arst_n_i;
  logic            res_valid_i;
  logic [XLEN-1:0] res_pc_i;
  logic [XLEN-1:0] res_target_i;
  logic            res_taken_i;
  logic            res_mispredict_i;
  logic            fetch_ready_i;
  logic            fetch_valid_o;
  logic [XLEN-1:0] fetch_pc_o;
  logic            pred_taken_o;
  logic [XLEN-1:0] pred_target_o;

  // Vector storage with one entry per cycle
  logic            v_res_valid [$];
  logic [XLEN-1:0] v_res_pc [$];
  logic [XLEN-1:0] v_res_target [$];
  logic            v_res_taken [$];
  logic            v_res_mispredict [$];
  logic            v_ready [$];
  logic [XLEN-1:0] v_exp_pc [$];
  logic            v_exp_taken [$];
  logic [XLEN-1:0] v_exp_target [$];

  int num_vec;
  int errors;
  bit loaded;

  bpred_top UUT (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .res_valid_i     (res_valid_i),
    .res_pc_i        (res_pc_i),
    .res_target_i    (res_target_i),
    .res_taken_i     (res_taken_i),
    .res_mispredict_i(res_mispredict_i),
    .fetch_ready_i   (fetch_ready_i),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_pc_o      (fetch_pc_o),
    .pred_taken_o    (pred_taken_o),
    .pred_target_o   (pred_target_o)
  );

  // Free running clock
  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Queue one cycle of stimulus and expected outputs
  task automatic add_vector(input logic            rv,
                            input logic [XLEN-1:0] rpc,
                            input logic [XLEN-1:0] rtgt,
                            input logic            rtaken,
                            input logic            rmis,
                            input logic            rdy,
                            input logic [XLEN-1:0] epc,
                            input logic            etaken,
                            input logic [XLEN-1:0] etgt);
    v_res_valid.push_back(rv);
    v_res_pc.push_back(rpc);
    v_res_target.push_back(rtgt);
    v_res_taken.push_back(rtaken);
    v_res_mispredict.push_back(rmis);
    v_ready.push_back(rdy);
    v_exp_pc.push_back(epc);
    v_exp_taken.push_back(etaken);
    v_exp_target.push_back(etgt);
  endtask

  // Parse the vector file and skip comment and blank lines
  task automatic load_vectors(output bit ok);
    int          fd;
    int          code;
    int          cnt;
    int          line_no;
    string       line;
    logic [31:0] f [9];
    ok      = 1'b1;
    line_no = 0;
    fd = $fopen("tests/bpred_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tests/bpred_vectors.txt");
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        line_no++;
        if (code == 0 || line.len() <= 1 || line.getc(0) == "#") begin
          continue;
        end
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
        if (cnt != 9) begin
          $display("Vector file line %0d has %0d fields instead of 9", line_no, cnt);
          errors++;
        end else begin
          add_vector(f[0][0], f[1], f[2], f[3][0], f[4][0], f[5][0],
                     f[6], f[7][0], f[8]);
        end
      end
      $fclose(fd);
      num_vec = v_exp_pc.size();
      if (num_vec == 0) begin
        $display("The vector file holds no vectors");
        ok = 1'b0;
      end
    end
  endtask

  // Evict a BTB entry whose gshare counter still predicts taken
  // Starts from the file's end state with history 4'hb and fetch PC 0x308
  task automatic add_eviction_vectors();
    // Taken mispredict at 0x80 allocates index 0 and loops back to 0x80
    add_vector(1'b1, 32'h80, 32'h80, 1'b1, 1'b1, 1'b0, 32'h308, 1'b0, 32'h0);
    // Counter 7 is taken so 0x80 hits, then a not-taken mispredict evicts it
    add_vector(1'b1, 32'h80, 32'h80, 1'b0, 1'b1, 1'b0, 32'h80, 1'b1, 32'h80);
    // Taken mispredict at 0x84 sends fetch back to 0x80
    add_vector(1'b1, 32'h84, 32'h80, 1'b1, 1'b1, 1'b0, 32'h84, 1'b0, 32'h0);
    // Counter d says taken but the evicted entry misses
    add_vector(1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1, 32'h80, 1'b0, 32'h0);
    // Sequential to 0x84, which hits its new entry under counter c
    add_vector(1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1, 32'h84, 1'b1, 32'h80);
  endtask

  // Stimulus for one cycle driven right on the rising edge
  task automatic apply_vector(input int idx);
    res_valid_i      <= v_res_valid[idx];
    res_pc_i         <= v_res_pc[idx];
    res_target_i     <= v_res_target[idx];
    res_taken_i      <= v_res_taken[idx];
    res_mispredict_i <= v_res_mispredict[idx];
    fetch_ready_i    <= v_ready[idx];
  endtask

  // Outputs of the current cycle against the vector
  task automatic check_outputs(input int idx);
    if (fetch_valid_o !== 1'b1) begin
      $display("[FAIL] %0t vector %0d fetch_valid_o expected 1 got %b",
               $time, idx, fetch_valid_o);
      errors++;
    end
    if (fetch_pc_o !== v_exp_pc[idx]) begin
      $display("[FAIL] %0t vector %0d fetch_pc_o expected %h got %h",
               $time, idx, v_exp_pc[idx], fetch_pc_o);
      errors++;
    end
    if (pred_taken_o !== v_exp_taken[idx]) begin
      $display("[FAIL] %0t vector %0d pred_taken_o expected %b got %b",
               $time, idx, v_exp_taken[idx], pred_taken_o);
      errors++;
    end
    // Target only means something on a taken prediction
    if (v_exp_taken[idx] && pred_target_o !== v_exp_target[idx]) begin
      $display("[FAIL] %0t vector %0d pred_target_o expected %h got %h",
               $time, idx, v_exp_target[idx], pred_target_o);
      errors++;
    end
  endtask

  // Watchdog sized from the vector count
  initial begin
    wait (loaded);
    #((num_vec + 20) * CLK_PERIOD);
    $display("Timeout after %0d vectors worth of cycles, run did not finish", num_vec + 20);
    $display("test failed");
    $finish;
  end

  initial begin
    bit ok;
    // Quiet inputs with reset held
    arst_n_i         = 1'b0;
    res_valid_i      = 1'b0;
    res_pc_i         = '0;
    res_target_i     = '0;
    res_taken_i      = 1'b0;
    res_mispredict_i = 1'b0;
    fetch_ready_i    = 1'b0;
    errors           = 0;
    num_vec          = 0;
    loaded           = 1'b0;
    void'($urandom(32'h5f88));

    load_vectors(ok);
    if (!ok) begin
      $display("Vector load failed, no cycles were run");
      $display("test failed");
      $finish;
    end else begin
      add_eviction_vectors();
      num_vec = v_exp_pc.size();
      loaded  = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_i);
      arst_n_i <= 1'b1;
      // Vector 0 lines up with the first cycle with fetch_valid_o high
      for (int i = 0; i < num_vec; i++) begin
        @(posedge clk_i);
        apply_vector(i);
        #(CLK_PERIOD - 1);
        check_outputs(i);
      end
      $display("Checked %0d vectors, %0d errors", num_vec, errors);
      if (errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

// File: verilog/bpred_top.sv
module bpred_top #(
  parameter int unsigned                HLEN     = 4,
  parameter int unsigned                BTB_BITS = 4,
  parameter bpred_pkg::c2b_t            INIT_C2B = bpred_pkg::WNT,
  parameter logic [bpred_pkg::XLEN-1:0] BOOT_PC  = '0
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       res_valid_i,
  input  logic [bpred_pkg::XLEN-1:0] res_pc_i,
  input  logic [bpred_pkg::XLEN-1:0] res_target_i,
  input  logic                       res_taken_i,
  input  logic                       res_mispredict_i,
  input  logic                       fetch_ready_i,
  output logic                       fetch_valid_o,
  output logic [bpred_pkg::XLEN-1:0] fetch_pc_o,
  output logic                       pred_taken_o,
  output logic [bpred_pkg::XLEN-1:0] pred_target_o
);

  // PC generator, fed back with the prediction for its own PC
  bpred_pc_gen #(
    .BOOT_PC(BOOT_PC)
  ) u_pc_gen (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .fetch_ready_i   (fetch_ready_i),
    .pred_taken_i    (pred_taken_o),
    .pred_target_i   (pred_target_o),
    .res_valid_i     (res_valid_i),
    .res_pc_i        (res_pc_i),
    .res_target_i    (res_target_i),
    .res_taken_i     (res_taken_i),
    .res_mispredict_i(res_mispredict_i),
    .fetch_valid_o   (fetch_valid_o),
    .curr_pc_o       (fetch_pc_o)
  );

  // Prediction looked up from the fetch PC in the same cycle
  bpu #(
    .HLEN    (HLEN),
    .BTB_BITS(BTB_BITS),
    .INIT_C2B(INIT_C2B)
  ) u_bpu (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .curr_pc_i       (fetch_pc_o),
    .res_valid_i     (res_valid_i),
    .res_pc_i        (res_pc_i),
    .res_target_i    (res_target_i),
    .res_taken_i     (res_taken_i),
    .res_mispredict_i(res_mispredict_i),
    .pred_taken_o    (pred_taken_o),
    .pred_target_o   (pred_target_o)
  );

endmodule

// File: verilog/bpred_pc_gen.sv
module bpred_pc_gen #(
  parameter logic [bpred_pkg::XLEN-1:0] BOOT_PC = '0
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       fetch_ready_i,
  input  logic                       pred_taken_i,
  input  logic [bpred_pkg::XLEN-1:0] pred_target_i,
  input  logic                       res_valid_i,
  input  logic [bpred_pkg::XLEN-1:0] res_pc_i,
  input  logic [bpred_pkg::XLEN-1:0] res_target_i,
  input  logic                       res_taken_i,
  input  logic                       res_mispredict_i,
  output logic                       fetch_valid_o,
  output logic [bpred_pkg::XLEN-1:0] curr_pc_o
);

  import bpred_pkg::*;

  // Byte distance to the next sequential instruction
  localparam logic [XLEN-1:0] INSTR_BYTES = XLEN'(1 << OFFSET);

  logic            valid_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_d;
  logic            redirect;
  logic            fetch_fire;

  // Branch unit overrides everything, even a stalled fetch
  assign redirect   = res_valid_i & res_mispredict_i;

  // Address handed over to fetch this cycle
  assign fetch_fire = valid_q & fetch_ready_i;

  // Next PC priority: redirect, prediction, sequential, hold
  always_comb begin
    pc_d = pc_q;
    if (redirect) begin
      pc_d = res_taken_i ? res_target_i : res_pc_i + INSTR_BYTES;
    end else if (fetch_fire) begin
      pc_d = pred_taken_i ? pred_target_i : pc_q + INSTR_BYTES;
    end
  end

  // PC register and valid flag
  // valid goes high on the first edge after reset and stays there
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      pc_q    <= BOOT_PC;
    end else begin
      valid_q <= 1'b1;
      pc_q    <= pc_d;
    end
  end

  assign fetch_valid_o = valid_q;
  assign curr_pc_o     = pc_q;

endmodule

// File: verilog/bpu.sv
module bpu #(
  parameter int unsigned     HLEN     = 4,
  parameter int unsigned     BTB_BITS = 4,
  parameter bpred_pkg::c2b_t INIT_C2B = bpred_pkg::WNT
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic [bpred_pkg::XLEN-1:0] curr_pc_i,
  input  logic                       res_valid_i,
  input  logic [bpred_pkg::XLEN-1:0] res_pc_i,
  input  logic [bpred_pkg::XLEN-1:0] res_target_i,
  input  logic                       res_taken_i,
  input  logic                       res_mispredict_i,
  output logic                       pred_taken_o,
  output logic [bpred_pkg::XLEN-1:0] pred_target_o
);

  import bpred_pkg::*;

  // Direction and target lookups
  logic                   gshare_taken;
  logic                   btb_hit;
  logic [XLEN-OFFSET-1:0] btb_target;

  // BTB control derived from the resolution
  logic                   btb_update;
  logic                   btb_del_entry;

  gshare #(
    .HLEN    (HLEN),
    .INIT_C2B(INIT_C2B)
  ) u_gshare (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .curr_pc_i  (curr_pc_i),
    .res_valid_i(res_valid_i),
    .res_pc_i   (res_pc_i),
    .res_taken_i(res_taken_i),
    .taken_o    (gshare_taken)
  );

  btb #(
    .BTB_BITS(BTB_BITS)
  ) u_btb (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .curr_pc_i   (curr_pc_i),
    .valid_i     (btb_update),
    .del_entry_i (btb_del_entry),
    .res_pc_i    (res_pc_i),
    .res_target_i(res_target_i),
    .hit_o       (btb_hit),
    .target_o    (btb_target)
  );

  // Taken branches allocate, not-taken mispredicts evict
  assign btb_update    = res_valid_i & res_taken_i;
  assign btb_del_entry = res_valid_i & res_mispredict_i & ~res_taken_i;

  // No target known means fall through
  assign pred_taken_o  = gshare_taken & btb_hit;
  assign pred_target_o = {btb_target, {OFFSET{1'b0}}};

endmodule

// File: verilog/btb.sv
module btb #(
  parameter int unsigned BTB_BITS = 4
) (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic [bpred_pkg::XLEN-1:0]                   curr_pc_i,
  input  logic                                         valid_i,
  input  logic                                         del_entry_i,
  input  logic [bpred_pkg::XLEN-1:0]                   res_pc_i,
  input  logic [bpred_pkg::XLEN-1:0]                   res_target_i,
  output logic                                         hit_o,
  output logic [bpred_pkg::XLEN-bpred_pkg::OFFSET-1:0] target_o
);

  import bpred_pkg::*;

  // Number of entries and width of the stored tag
  localparam int unsigned BTB_ROWS = 2 ** BTB_BITS;
  localparam int unsigned TAG_W    = XLEN - BTB_BITS - OFFSET;

  // Entry storage
  logic                   valid_q  [BTB_ROWS];
  logic [TAG_W-1:0]       tag_q    [BTB_ROWS];
  logic [XLEN-OFFSET-1:0] target_q [BTB_ROWS];

  // Lookup fields from the fetch PC
  logic [BTB_BITS-1:0]    rd_idx;
  logic [TAG_W-1:0]       rd_tag;

  // Update fields from the resolved PC
  logic [BTB_BITS-1:0]    wr_idx;
  logic [TAG_W-1:0]       wr_tag;
  logic                   wr_tag_match;

  assign rd_idx = curr_pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign rd_tag = curr_pc_i[XLEN-1:BTB_BITS+OFFSET];
  assign wr_idx = res_pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign wr_tag = res_pc_i[XLEN-1:BTB_BITS+OFFSET];

  // Only the branch that owns the entry may remove it
  assign wr_tag_match = tag_q[wr_idx] == wr_tag;

  // Hit needs a live entry with the same tag
  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign target_o = target_q[rd_idx];

  // Valid bits cleared on reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < BTB_ROWS; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (valid_i) begin
      valid_q[wr_idx] <= 1'b1;
    end else if (del_entry_i && wr_tag_match) begin
      // Not-taken mispredict drops the entry
      valid_q[wr_idx] <= 1'b0;
    end
  end

  // Tag and target payload
  // Written on every taken resolution
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= res_target_i[XLEN-1:OFFSET];
    end
  end

endmodule

// File: verilog/gshare.sv
module gshare #(
  parameter int unsigned      HLEN     = 4,
  parameter bpred_pkg::c2b_t  INIT_C2B = bpred_pkg::WNT
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic [bpred_pkg::XLEN-1:0] curr_pc_i,
  input  logic                       res_valid_i,
  input  logic [bpred_pkg::XLEN-1:0] res_pc_i,
  input  logic                       res_taken_i,
  output logic                       taken_o
);

  import bpred_pkg::*;

  // One counter per history/PC combination
  localparam int unsigned PHT_SIZE = 2 ** HLEN;

  // Global history, newest outcome in bit 0
  logic [HLEN-1:0] hist_q;

  // Pattern history table
  c2b_t            pht_q [PHT_SIZE];

  // Lookup and update indices
  logic [HLEN-1:0] rd_idx;
  logic [HLEN-1:0] wr_idx;
  c2b_t            rd_cnt;

  // Saturating step toward the resolved direction
  function automatic c2b_t c2b_step(input c2b_t cnt, input logic taken);
    c2b_t nxt;
    nxt = cnt;
    case (cnt)
      SNT:     nxt = taken ? WNT : SNT;
      WNT:     nxt = taken ? WT  : SNT;
      WT:      nxt = taken ? ST  : WNT;
      ST:      nxt = taken ? ST  : WT;
      default: nxt = cnt;
    endcase
    return nxt;
  endfunction

  // Fetch side: PC bits above the offset hashed with history
  assign rd_idx = curr_pc_i[HLEN+OFFSET-1:OFFSET] ^ hist_q;
  assign rd_cnt = pht_q[rd_idx];

  // Resolve side uses the history as it stands before the shift
  assign wr_idx = res_pc_i[HLEN+OFFSET-1:OFFSET] ^ hist_q;

  // Taken when the counter sits in either taken state
  assign taken_o = (rd_cnt == WT) || (rd_cnt == ST);

  // History register
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hist_q <= '0;
    end else if (res_valid_i) begin
      // Shift in the resolved outcome
      hist_q <= {hist_q[HLEN-2:0], res_taken_i};
    end
  end

  // Counter table
  // All counters start from the same configurable state
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < PHT_SIZE; i++) begin
        pht_q[i] <= INIT_C2B;
      end
    end else if (res_valid_i) begin
      pht_q[wr_idx] <= c2b_step(pht_q[wr_idx], res_taken_i);
    end
  end

endmodule

// File: verilog/bpred_pkg.sv
package bpred_pkg;

  // Address width of the core
  localparam int unsigned XLEN = 32;

  // Low PC bits that are always zero
  // 32-bit instructions only, so the two LSBs carry no information
  localparam int unsigned OFFSET = 2;

  // Two-bit saturating counter states
  // MSB set means the branch is predicted taken
  typedef enum logic [1:0] {
    SNT = 2'b00,  // Strongly not taken
    WNT = 2'b01,  // Weakly not taken
    WT  = 2'b10,  // Weakly taken
    ST  = 2'b11   // Strongly taken
  } c2b_t;

endpackage
